// ==== bench/tb_req_path.sv ====
`timescale 1ns/10ps

module tb_req_path import lynx_pkg::*; ();

  typedef struct packed {
    logic [ID_BITS-1:0]    id;
    opcode_t               opc;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0]   len;
    logic                  last;
  } chunk_t;

  typedef struct packed {
    logic [ID_BITS-1:0] id;
    opcode_t            opc;
    strm_t              strm;
  } cpl_t;

  logic                  aclk, arst_n;
  logic                  s_req_valid, s_req_ready;
  logic [ID_BITS-1:0]    s_req_id, m_host_chunk_id, m_card_chunk_id, m_cpl_id;
  opcode_t               s_req_opcode, m_host_chunk_opcode, m_card_chunk_opcode, m_cpl_opcode;
  strm_t                 s_req_strm, m_cpl_strm;
  logic [VADDR_BITS-1:0] s_req_vaddr, m_host_chunk_vaddr, m_card_chunk_vaddr;
  logic [LEN_BITS-1:0]   s_req_len, m_host_chunk_len, m_card_chunk_len;
  logic                  m_host_chunk_valid, m_host_chunk_ready, m_host_chunk_last;
  logic                  m_card_chunk_valid, m_card_chunk_ready, m_card_chunk_last;
  logic                  m_cpl_valid, m_cpl_ready;

  chunk_t      exp_host[$], exp_card[$];         // Expected chunks per stream
  cpl_t        exp_cpl_host[$], exp_cpl_card[$]; // Expected completions, request order
  int          err_mismatch, err_other;
  int          cycles, cycle_limit;              // Timeout bookkeeping
  logic [31:0] rnd;                              // Ready pattern state
  logic        rand_ready, stall_host;

  req_path_top u_req_path_top (.*);

  always #5 aclk = ~aclk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready inputs change on the falling edge only
  always @(negedge aclk) begin
    rnd = xorshift(rnd);
    m_host_chunk_ready = !stall_host && (!rand_ready || rnd[0]);
    m_card_chunk_ready = !rand_ready || rnd[8];
    m_cpl_ready        = !rand_ready || rnd[16] || rnd[17];  // Busier than the chunk sides
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, traffic did not drain", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ============================================================
  // Reference model and checks
  // ============================================================

  // Cut at every PMTU boundary, last flag on the final piece
  task automatic model_req(input logic [ID_BITS-1:0] id, input opcode_t opc, input strm_t strm,
                           input logic [VADDR_BITS-1:0] vaddr, input logic [LEN_BITS-1:0] len);
    chunk_t c;
    int     rem, room;
    c.id    = id;
    c.opc   = opc;
    c.vaddr = vaddr;
    rem     = int'(len);
    while (rem != 0) begin
      room   = PMTU_BYTES - int'(c.vaddr[PMTU_BITS-1:0]);  // Bytes to next boundary
      c.last = (rem <= room);
      c.len  = LEN_BITS'(c.last ? rem : room);
      if (strm == STRM_HOST) exp_host.push_back(c);
      else exp_card.push_back(c);
      c.vaddr = c.vaddr + VADDR_BITS'(c.len);
      rem     = rem - int'(c.len);
    end
    if (strm == STRM_HOST) exp_cpl_host.push_back({id, opc, strm});
    else exp_cpl_card.push_back({id, opc, strm});
  endtask

  task automatic cmp_chunk(input strm_t side, input chunk_t got, input chunk_t exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("MISMATCH @%0t: %s chunk got id=%h opc=%0d va=%h len=%0d last=%b", $time,
               side == STRM_HOST ? "host" : "card", got.id, got.opc, got.vaddr, got.len, got.last);
      $display("  expected id=%h opc=%0d va=%h len=%0d last=%b",
               exp.id, exp.opc, exp.vaddr, exp.len, exp.last);
    end
  endtask

  task automatic cmp_cpl(input cpl_t got, input cpl_t exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("MISMATCH @%0t: completion got id=%h opc=%0d strm=%0d, expected id=%h opc=%0d strm=%0d",
               $time, got.id, got.opc, got.strm, exp.id, exp.opc, exp.strm);
    end
  endtask

  task automatic take_chunk(input strm_t side, input chunk_t got);
    if ((side == STRM_HOST) ? (exp_host.size() == 0) : (exp_card.size() == 0)) begin
      err_other++;
      $display("Chunk on the %s output at %0t with no chunk outstanding",
               side == STRM_HOST ? "host" : "card", $time);
    end else if (side == STRM_HOST) cmp_chunk(side, got, exp_host.pop_front());
    else cmp_chunk(side, got, exp_card.pop_front());
  endtask

  task automatic take_cpl(input cpl_t got);
    if ((got.strm == STRM_HOST) ? (exp_cpl_host.size() == 0) : (exp_cpl_card.size() == 0)) begin
      err_other++;
      $display("Completion at %0t for stream %0d with no request outstanding", $time, got.strm);
    end else if (got.strm == STRM_HOST) cmp_cpl(got, exp_cpl_host.pop_front());
    else cmp_cpl(got, exp_cpl_card.pop_front());
  endtask

  // Pre-edge values, so the DUT's own updates do not race the sampling
  always @(posedge aclk) begin
    if (arst_n) begin
      if (m_host_chunk_valid && m_host_chunk_ready)
        take_chunk(STRM_HOST, {m_host_chunk_id, m_host_chunk_opcode, m_host_chunk_vaddr,
                               m_host_chunk_len, m_host_chunk_last});
      if (m_card_chunk_valid && m_card_chunk_ready)
        take_chunk(STRM_CARD, {m_card_chunk_id, m_card_chunk_opcode, m_card_chunk_vaddr,
                               m_card_chunk_len, m_card_chunk_last});
      if (m_cpl_valid && m_cpl_ready) take_cpl({m_cpl_id, m_cpl_opcode, m_cpl_strm});
    end
  end

  // ============================================================
  // Stimulus and directed tests
  // ============================================================
  task automatic send_req(input logic [ID_BITS-1:0] id, input opcode_t opc, input strm_t strm,
                          input logic [VADDR_BITS-1:0] vaddr, input logic [LEN_BITS-1:0] len);
    model_req(id, opc, strm, vaddr, len);
    cycle_limit += 8 * (int'(len) / PMTU_BYTES + 4);  // Room for random stalls
    @(negedge aclk);
    s_req_valid  = 1'b1;
    s_req_id     = id;
    s_req_opcode = opc;
    s_req_strm   = strm;
    s_req_vaddr  = vaddr;
    s_req_len    = len;
    do @(posedge aclk); while (!s_req_ready);
  endtask

  task automatic drain(input string name);
    @(negedge aclk);
    s_req_valid = 1'b0;
    while (exp_host.size() + exp_card.size() + exp_cpl_host.size() + exp_cpl_card.size() != 0)
      @(posedge aclk);
    repeat (5) @(negedge aclk);                       // Catch late duplicates
    cycle_limit += 10;
    $display("%s finished at %0t", name, $time);
  endtask

  task automatic check_idle(input string when);
    if (m_host_chunk_valid || m_card_chunk_valid || m_cpl_valid) begin
      err_other++;
      $display("A valid output is high %s at %0t", when, $time);
    end
  endtask

  task automatic test_reset;
    repeat (10) begin
      @(negedge aclk);
      check_idle("during reset");
    end
    arst_n = 1'b1;
    repeat (3) begin
      @(negedge aclk);
      check_idle("after reset");
    end
  endtask

  task automatic test_routing;
    send_req(4'h1, OPC_READ,  STRM_HOST, 32'h0000_1000, 16'd64);
    send_req(4'h2, OPC_WRITE, STRM_CARD, 32'h0000_2000, 16'd128);
    send_req(4'h3, OPC_WRITE, STRM_HOST, 32'h0000_3000, 16'd32);
    send_req(4'h4, OPC_READ,  STRM_CARD, 32'h0000_4000, 16'd200);
    drain("routing");
  endtask

  // Unaligned starts, several PMTUs, exact fit and zero length
  task automatic frag_set;
    send_req(4'h5, OPC_READ,  STRM_HOST, 32'h0000_10f3, 16'd700);
    send_req(4'h6, OPC_WRITE, STRM_CARD, 32'h8000_01ff, 16'd515);
    send_req(4'h7, OPC_READ,  STRM_HOST, 32'h0000_2100, 16'd256);
    send_req(4'h8, OPC_WRITE, STRM_CARD, 32'h0000_3080, 16'd0);
    send_req(4'h9, OPC_READ,  STRM_HOST, 32'h0123_45fe, 16'd1030);
    send_req(4'ha, OPC_WRITE, STRM_HOST, 32'h0000_0001, 16'd0);
  endtask

  task automatic merge_set;
    for (int i = 0; i < 12; i++)
      send_req(ID_BITS'(i), opcode_t'(i[1]), strm_t'(i[0] ^ i[2]),
               32'h4000_0000 + VADDR_BITS'(i * 97), LEN_BITS'((i * 53) % 320));
  endtask

  task automatic test_backpressure;
    rand_ready = 1'b1;
    frag_set();
    merge_set();
    drain("random ready");
    stall_host   = 1'b1;                              // Host chunk side held off
    cycle_limit += 150;
    send_req(4'hb, OPC_WRITE, STRM_HOST, 32'h0000_5010, 16'd900);
    send_req(4'hc, OPC_READ,  STRM_CARD, 32'h0000_6020, 16'd100);
    send_req(4'hd, OPC_READ,  STRM_HOST, 32'h0000_7000, 16'd40);
    send_req(4'he, OPC_WRITE, STRM_CARD, 32'h0000_80f0, 16'd400);
    @(negedge aclk);
    s_req_valid = 1'b0;
    repeat (150) @(negedge aclk);
    if (exp_card.size() != 0) begin
      err_other++;
      $display("Card chunks stopped while only the host side was stalled");
    end
    stall_host = 1'b0;
    drain("long stall");
    rand_ready = 1'b0;
  endtask

  initial begin
    aclk = 1'b0;
    arst_n = 1'b0;
    s_req_valid = 1'b0;
    s_req_id = '0;
    s_req_opcode = OPC_READ;
    s_req_strm = STRM_HOST;
    s_req_vaddr = '0;
    s_req_len = '0;
    m_host_chunk_ready = 1'b1;
    m_card_chunk_ready = 1'b1;
    m_cpl_ready = 1'b1;
    rnd = 32'h22c5_2e1f;
    rand_ready = 1'b0;
    stall_host = 1'b0;
    err_mismatch = 0;
    err_other = 0;
    cycles = 0;
    cycle_limit = 100;                                 // Reset plus slack
    test_reset();
    test_routing();
    frag_set();
    drain("fragmentation");
    merge_set();
    drain("completion merge");
    test_backpressure();
    $display("Result: %0d mismatches, %0d other errors", err_mismatch, err_other);
    if (err_mismatch + err_other == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== design/cpl_arbiter.sv ====
`timescale 1ns/10ps

module cpl_arbiter import lynx_pkg::*; (
  input  logic               aclk,
  input  logic               arst_n,
  // Host completions
  input  logic               host_cpl_valid,
  output logic               host_cpl_ready,
  input  logic [ID_BITS-1:0] host_cpl_id,
  input  opcode_t            host_cpl_opcode,
  // Card completions
  input  logic               card_cpl_valid,
  output logic               card_cpl_ready,
  input  logic [ID_BITS-1:0] card_cpl_id,
  input  opcode_t            card_cpl_opcode,
  // Merged completions
  output logic               m_cpl_valid,
  input  logic               m_cpl_ready,
  output logic [ID_BITS-1:0] m_cpl_id,
  output opcode_t            m_cpl_opcode,
  output strm_t              m_cpl_strm
);

  strm_t               last_q;              // Side that won last
  logic                gnt_card;            // Card wins this cycle
  strm_t               gnt_strm;
  logic                arb_valid, arb_ready;
  logic [CPL_BITS-1:0] arb_word, out_word;

  // ============================================================
  // Round-robin grant
  // ============================================================

  // Card wins when alone, or on a tie if host won last time
  assign gnt_card = card_cpl_valid && (!host_cpl_valid || last_q == STRM_HOST);
  assign gnt_strm = gnt_card ? STRM_CARD : STRM_HOST;

  assign arb_valid      = host_cpl_valid || card_cpl_valid;
  assign host_cpl_ready = arb_ready && !gnt_card;
  assign card_cpl_ready = arb_ready && gnt_card;

  // Winner's word with its stream tag
  always_comb begin
    if (gnt_card) begin
      arb_word = {card_cpl_id, card_cpl_opcode, STRM_CARD};
    end else begin
      arb_word = {host_cpl_id, host_cpl_opcode, STRM_HOST};
    end
  end

  // Pointer moves only when a completion is actually taken
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      last_q <= STRM_CARD;                  // Host goes first after reset
    end else if (arb_valid && arb_ready) begin
      last_q <= gnt_strm;
    end
  end

  // ============================================================
  // Output slice
  // ============================================================
  meta_reg #(.DATA_BITS(CPL_BITS)) u_reg_cpl (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(arb_valid), .s_ready(arb_ready), .s_data(arb_word),
    .m_valid(m_cpl_valid), .m_ready(m_cpl_ready), .m_data(out_word)
  );

  // Unpack {id, opcode, strm}
  assign m_cpl_id     = out_word[CPL_BITS-1 -: ID_BITS];
  assign m_cpl_opcode = opcode_t'(out_word[1]);
  assign m_cpl_strm   = strm_t'(out_word[0]);

endmodule

// ==== design/lynx_pkg.sv ====
package lynx_pkg;

  // ============================================================
  // Field widths
  // ============================================================
  localparam int VADDR_BITS = 32;           // Virtual address
  localparam int LEN_BITS   = 16;           // Byte length of a request
  localparam int ID_BITS    = 4;            // Request tag

  // ============================================================
  // Chunk boundary
  // ============================================================
  localparam int PMTU_BYTES = 256;          // No chunk may cross this
  localparam int PMTU_BITS  = 8;            // log2(PMTU_BYTES)

  // ============================================================
  // Enums
  // ============================================================

  // Stream target of a request
  typedef enum logic {
    STRM_HOST = 1'b0,                       // Host memory side
    STRM_CARD = 1'b1                        // Card memory side
  } strm_t;

  // Request opcode
  typedef enum logic {
    OPC_READ  = 1'b0,
    OPC_WRITE = 1'b1
  } opcode_t;

  // ============================================================
  // Packed word widths
  // ============================================================

  // Request word {id, opcode, vaddr, len}, stream already stripped
  localparam int REQ_BITS = ID_BITS + $bits(opcode_t) + VADDR_BITS + LEN_BITS;

  // Completion word {id, opcode, strm}
  localparam int CPL_BITS = ID_BITS + $bits(opcode_t) + $bits(strm_t);

endpackage

// ==== design/meta_reg.sv ====
`timescale 1ns/10ps

module meta_reg #(
  parameter int DATA_BITS = 32              // Width of the carried word
) (
  input  logic                 aclk,
  input  logic                 arst_n,
  // Slave side
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic [DATA_BITS-1:0] s_data,
  // Master side
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic [DATA_BITS-1:0] m_data
);

  // Take a word when empty or when the held one leaves this cycle
  assign s_ready = !m_valid || m_ready;

  // Occupancy flag
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      m_valid <= 1'b1;                      // New word lands
    end else if (m_ready) begin
      m_valid <= 1'b0;                      // Drained, nothing behind it
    end
  end

  // Payload
  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_data <= s_data;
    end
  end

  // ============================================================
  // Checks
  // ============================================================

  // A stalled word must stay put until the consumer takes it
  property p_stall_hold;
    @(posedge aclk) disable iff (!arst_n)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_data));
  endproperty
  a_stall_hold: assert property (p_stall_hold)
    else $error("meta_reg: output word dropped or changed while stalled");

endmodule

// ==== design/req_fragmenter.sv ====
`timescale 1ns/10ps

module req_fragmenter import lynx_pkg::*; (
  input  logic                  aclk,
  input  logic                  arst_n,
  // Request in
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic [ID_BITS-1:0]    req_id,
  input  opcode_t               req_opcode,
  input  logic [VADDR_BITS-1:0] req_vaddr,
  input  logic [LEN_BITS-1:0]   req_len,
  // Chunks out
  output logic                  chunk_valid,
  input  logic                  chunk_ready,
  output logic [ID_BITS-1:0]    chunk_id,
  output opcode_t               chunk_opcode,
  output logic [VADDR_BITS-1:0] chunk_vaddr,
  output logic [LEN_BITS-1:0]   chunk_len,
  output logic                  chunk_last,
  // Completion out
  output logic                  cpl_valid,
  input  logic                  cpl_ready,
  output logic [ID_BITS-1:0]    cpl_id,
  output opcode_t               cpl_opcode
);

  typedef enum logic [1:0] {
    FRAG_IDLE,                              // Waiting for a request
    FRAG_CHUNK,                             // Issuing chunks
    FRAG_CPL                                // Completion pending
  } frag_state_t;

  frag_state_t           state_q;
  logic [VADDR_BITS-1:0] vaddr_q;           // Address of next chunk
  logic [LEN_BITS-1:0]   rem_q;             // Bytes still to send
  logic [ID_BITS-1:0]    id_q;
  opcode_t               opc_q;
  logic [PMTU_BITS:0]    room;              // Bytes up to next boundary, 1..PMTU
  logic                  req_fire, chunk_fire, cpl_fire;

  assign req_ready   = (state_q == FRAG_IDLE);
  assign chunk_valid = (state_q == FRAG_CHUNK);
  assign cpl_valid   = (state_q == FRAG_CPL);

  assign req_fire   = req_valid && req_ready;
  assign chunk_fire = chunk_valid && chunk_ready;
  assign cpl_fire   = cpl_valid && cpl_ready;

  // ============================================================
  // Boundary rule
  // ============================================================
  assign room = (PMTU_BITS+1)'(PMTU_BYTES) - {1'b0, vaddr_q[PMTU_BITS-1:0]};

  always_comb begin
    chunk_last = (rem_q <= LEN_BITS'(room));         // Rest fits before boundary
    chunk_len  = chunk_last ? rem_q : LEN_BITS'(room);
  end

  assign chunk_id     = id_q;
  assign chunk_opcode = opc_q;
  assign chunk_vaddr  = vaddr_q;
  assign cpl_id       = id_q;
  assign cpl_opcode   = opc_q;

  // ============================================================
  // FSM
  // ============================================================
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= FRAG_IDLE;
    end else begin
      case (state_q)
        FRAG_IDLE:  if (req_fire) state_q <= (req_len == '0) ? FRAG_CPL : FRAG_CHUNK;
        FRAG_CHUNK: if (chunk_fire && chunk_last) state_q <= FRAG_CPL;
        FRAG_CPL:   if (cpl_fire) state_q <= FRAG_IDLE;
        default:    state_q <= FRAG_IDLE;
      endcase
    end
  end

  // Request payload and progress
  always_ff @(posedge aclk) begin
    if (req_fire) begin
      vaddr_q <= req_vaddr;
      rem_q   <= req_len;
      id_q    <= req_id;
      opc_q   <= req_opcode;
    end else if (chunk_fire) begin
      vaddr_q <= vaddr_q + VADDR_BITS'(chunk_len);   // Step past this chunk
      rem_q   <= rem_q - chunk_len;
    end
  end

  // ============================================================
  // Checks
  // ============================================================

  // Chunk never empty and never wider than one PMTU
  property p_chunk_len;
    @(posedge aclk) disable iff (!arst_n)
      chunk_valid |-> (chunk_len != '0) && (chunk_len <= LEN_BITS'(PMTU_BYTES));
  endproperty
  a_chunk_len: assert property (p_chunk_len)
    else $error("req_fragmenter: chunk length out of range");

endmodule

// ==== design/req_mux_stream_1_2.sv ====
`timescale 1ns/10ps

module req_mux_stream_1_2 import lynx_pkg::*; (
  input  logic                  aclk,
  input  logic                  arst_n,
  // Incoming requests
  input  logic                  s_req_valid,
  output logic                  s_req_ready,
  input  logic [ID_BITS-1:0]    s_req_id,
  input  opcode_t               s_req_opcode,
  input  strm_t                 s_req_strm,
  input  logic [VADDR_BITS-1:0] s_req_vaddr,
  input  logic [LEN_BITS-1:0]   s_req_len,
  // Host side
  output logic                  host_req_valid,
  input  logic                  host_req_ready,
  output logic [ID_BITS-1:0]    host_req_id,
  output opcode_t               host_req_opcode,
  output logic [VADDR_BITS-1:0] host_req_vaddr,
  output logic [LEN_BITS-1:0]   host_req_len,
  // Card side
  output logic                  card_req_valid,
  input  logic                  card_req_ready,
  output logic [ID_BITS-1:0]    card_req_id,
  output opcode_t               card_req_opcode,
  output logic [VADDR_BITS-1:0] card_req_vaddr,
  output logic [LEN_BITS-1:0]   card_req_len
);

  logic                host_in_valid, host_in_ready;  // Slice inputs
  logic                card_in_valid, card_in_ready;
  logic [REQ_BITS-1:0] req_word;                      // Stream bit dropped
  logic [REQ_BITS-1:0] host_word, card_word;          // Slice outputs

  // ============================================================
  // Steering
  // ============================================================
  always_comb begin
    host_in_valid = 1'b0;
    card_in_valid = 1'b0;
    s_req_ready   = 1'b0;
    if (s_req_valid) begin
      if (s_req_strm == STRM_HOST) begin
        host_in_valid = 1'b1;
        s_req_ready   = host_in_ready;      // Only the chosen side counts
      end else begin
        card_in_valid = 1'b1;
        s_req_ready   = card_in_ready;
      end
    end
  end

  assign req_word = {s_req_id, s_req_opcode, s_req_vaddr, s_req_len};

  // One slice per side
  meta_reg #(.DATA_BITS(REQ_BITS)) u_reg_host (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(host_in_valid), .s_ready(host_in_ready), .s_data(req_word),
    .m_valid(host_req_valid), .m_ready(host_req_ready), .m_data(host_word)
  );

  meta_reg #(.DATA_BITS(REQ_BITS)) u_reg_card (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(card_in_valid), .s_ready(card_in_ready), .s_data(req_word),
    .m_valid(card_req_valid), .m_ready(card_req_ready), .m_data(card_word)
  );

  // Unpack {id, opcode, vaddr, len}
  assign host_req_id     = host_word[REQ_BITS-1 -: ID_BITS];
  assign host_req_opcode = opcode_t'(host_word[LEN_BITS+VADDR_BITS]);
  assign host_req_vaddr  = host_word[LEN_BITS +: VADDR_BITS];
  assign host_req_len    = host_word[LEN_BITS-1:0];

  assign card_req_id     = card_word[REQ_BITS-1 -: ID_BITS];
  assign card_req_opcode = opcode_t'(card_word[LEN_BITS+VADDR_BITS]);
  assign card_req_vaddr  = card_word[LEN_BITS +: VADDR_BITS];
  assign card_req_len    = card_word[LEN_BITS-1:0];

endmodule

// ==== design/req_path_top.sv ====
`timescale 1ns/10ps

module req_path_top import lynx_pkg::*; (
  input  logic                  aclk,
  input  logic                  arst_n,
  // Host requests
  input  logic                  s_req_valid,
  output logic                  s_req_ready,
  input  logic [ID_BITS-1:0]    s_req_id,
  input  opcode_t               s_req_opcode,
  input  strm_t                 s_req_strm,
  input  logic [VADDR_BITS-1:0] s_req_vaddr,
  input  logic [LEN_BITS-1:0]   s_req_len,
  // Host-memory chunks
  output logic                  m_host_chunk_valid,
  input  logic                  m_host_chunk_ready,
  output logic [ID_BITS-1:0]    m_host_chunk_id,
  output opcode_t               m_host_chunk_opcode,
  output logic [VADDR_BITS-1:0] m_host_chunk_vaddr,
  output logic [LEN_BITS-1:0]   m_host_chunk_len,
  output logic                  m_host_chunk_last,
  // Card-memory chunks
  output logic                  m_card_chunk_valid,
  input  logic                  m_card_chunk_ready,
  output logic [ID_BITS-1:0]    m_card_chunk_id,
  output opcode_t               m_card_chunk_opcode,
  output logic [VADDR_BITS-1:0] m_card_chunk_vaddr,
  output logic [LEN_BITS-1:0]   m_card_chunk_len,
  output logic                  m_card_chunk_last,
  // Merged completions
  output logic                  m_cpl_valid,
  input  logic                  m_cpl_ready,
  output logic [ID_BITS-1:0]    m_cpl_id,
  output opcode_t               m_cpl_opcode,
  output strm_t                 m_cpl_strm
);

  // Mux to fragmenters
  logic                  host_req_valid, host_req_ready;
  logic [ID_BITS-1:0]    host_req_id;
  opcode_t               host_req_opcode;
  logic [VADDR_BITS-1:0] host_req_vaddr;
  logic [LEN_BITS-1:0]   host_req_len;
  logic                  card_req_valid, card_req_ready;
  logic [ID_BITS-1:0]    card_req_id;
  opcode_t               card_req_opcode;
  logic [VADDR_BITS-1:0] card_req_vaddr;
  logic [LEN_BITS-1:0]   card_req_len;
  // Fragmenters to arbiter
  logic                  host_cpl_valid, host_cpl_ready;
  logic [ID_BITS-1:0]    host_cpl_id;
  opcode_t               host_cpl_opcode;
  logic                  card_cpl_valid, card_cpl_ready;
  logic [ID_BITS-1:0]    card_cpl_id;
  opcode_t               card_cpl_opcode;

  // ============================================================
  // Routing by stream target
  // ============================================================
  req_mux_stream_1_2 u_mux (
    .aclk(aclk), .arst_n(arst_n),
    .s_req_valid(s_req_valid), .s_req_ready(s_req_ready), .s_req_id(s_req_id),
    .s_req_opcode(s_req_opcode), .s_req_strm(s_req_strm),
    .s_req_vaddr(s_req_vaddr), .s_req_len(s_req_len),
    .host_req_valid(host_req_valid), .host_req_ready(host_req_ready),
    .host_req_id(host_req_id), .host_req_opcode(host_req_opcode),
    .host_req_vaddr(host_req_vaddr), .host_req_len(host_req_len),
    .card_req_valid(card_req_valid), .card_req_ready(card_req_ready),
    .card_req_id(card_req_id), .card_req_opcode(card_req_opcode),
    .card_req_vaddr(card_req_vaddr), .card_req_len(card_req_len)
  );

  // ============================================================
  // Per-stream fragmenters
  // ============================================================
  req_fragmenter u_frag_host (
    .aclk(aclk), .arst_n(arst_n),
    .req_valid(host_req_valid), .req_ready(host_req_ready), .req_id(host_req_id),
    .req_opcode(host_req_opcode), .req_vaddr(host_req_vaddr), .req_len(host_req_len),
    .chunk_valid(m_host_chunk_valid), .chunk_ready(m_host_chunk_ready),
    .chunk_id(m_host_chunk_id), .chunk_opcode(m_host_chunk_opcode),
    .chunk_vaddr(m_host_chunk_vaddr), .chunk_len(m_host_chunk_len),
    .chunk_last(m_host_chunk_last),
    .cpl_valid(host_cpl_valid), .cpl_ready(host_cpl_ready),
    .cpl_id(host_cpl_id), .cpl_opcode(host_cpl_opcode)
  );

  req_fragmenter u_frag_card (
    .aclk(aclk), .arst_n(arst_n),
    .req_valid(card_req_valid), .req_ready(card_req_ready), .req_id(card_req_id),
    .req_opcode(card_req_opcode), .req_vaddr(card_req_vaddr), .req_len(card_req_len),
    .chunk_valid(m_card_chunk_valid), .chunk_ready(m_card_chunk_ready),
    .chunk_id(m_card_chunk_id), .chunk_opcode(m_card_chunk_opcode),
    .chunk_vaddr(m_card_chunk_vaddr), .chunk_len(m_card_chunk_len),
    .chunk_last(m_card_chunk_last),
    .cpl_valid(card_cpl_valid), .cpl_ready(card_cpl_ready),
    .cpl_id(card_cpl_id), .cpl_opcode(card_cpl_opcode)
  );

  // ============================================================
  // Completion merge
  // ============================================================
  cpl_arbiter u_cpl_arb (
    .aclk(aclk), .arst_n(arst_n),
    .host_cpl_valid(host_cpl_valid), .host_cpl_ready(host_cpl_ready),
    .host_cpl_id(host_cpl_id), .host_cpl_opcode(host_cpl_opcode),
    .card_cpl_valid(card_cpl_valid), .card_cpl_ready(card_cpl_ready),
    .card_cpl_id(card_cpl_id), .card_cpl_opcode(card_cpl_opcode),
    .m_cpl_valid(m_cpl_valid), .m_cpl_ready(m_cpl_ready), .m_cpl_id(m_cpl_id),
    .m_cpl_opcode(m_cpl_opcode), .m_cpl_strm(m_cpl_strm)
  );

endmodule

// ==== filelist.f ====
design/lynx_pkg.sv
design/meta_reg.sv
design/req_mux_stream_1_2.sv
design/req_fragmenter.sv
design/cpl_arbiter.sv
design/req_path_top.sv
bench/tb_req_path.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the request path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_req_path \
  -o sim_req_path > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_req_path > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0
